// File: verilog.f
common/csd_cfg_pkg.sv
common/csd_seq_pkg.sv
hdl/csd_scan_sequencer.sv
hdl/csd_scan_counter.sv
precharge/csd_prescaler.sv
precharge/csd_prs_gen.sv
hdl/csd_clock_gen.sv
testbench/tb_csd_clock_gen.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the clock generator testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wall -f verilog.f \
    --top-module tb_csd_clock_gen -o sim_tb > sim.log 2>&1 \
    && ./obj_dir/sim_tb >> sim.log 2>&1 \
    || echo "simulation returned an error" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 \
    || grep -q "ALL TESTS PASSED" sim.log \
    || exit 1

// File: testbench/tb_csd_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csd_clock_gen;

    logic op_clock;
    logic inter_reset;
    logic enable;
    logic ctrl_wr;
    logic [csd_seq_pkg::CTRL_W-1:0] ctrl_wdata;
    logic dpulse;
    logic ppulse;
    logic start0;
    logic start1;
    logic mesrst;
    logic shield;

    logic [31:0] lfsr_state;                     // Random source for channel bits and freeze time.
    logic chk_idle, meas_pending, chk_start, chk_stopped; // Phase flags that arm assertions.
    logic chk_scan, chk_pre, chk_frz, prs_sample, prs_done;
    logic exp_ch0, exp_ch1, exp_msb, prs_first, prs_toggled;
    logic [csd_seq_pkg::CTRL_W-1:0] ch_bits;     // Channel enables placed at their positions.
    logic [7:0] prs_model;                       // Reference copy of the 8-bit PRS register.
    int rises, gap, pre_changes, run_len;
    logic dpulse_prev, ppulse_prev;
    int wait_cnt, frz_len;

    csd_clock_gen u_csd_clock_gen
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .enable      (enable),
        .ctrl_wr     (ctrl_wr),
        .ctrl_wdata  (ctrl_wdata),
        .dpulse      (dpulse),
        .ppulse      (ppulse),
        .start0      (start0),
        .start1      (start1),
        .mesrst      (mesrst),
        .shield      (shield)
    );

    initial
    begin
        op_clock = 1'b0;
        forever #50 op_clock = ~op_clock;        // 100 ns period.
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);                     // Say what went wrong first.
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);      // One step for each bit taken.
        b = lfsr_state[0];
    endtask

    // The word lands in the DUT on the second rising edge.
    task automatic write_ctrl(input logic [csd_seq_pkg::CTRL_W-1:0] w);
        @(posedge op_clock);
        ctrl_wr <= 1'b1;
        ctrl_wdata <= w;
        @(posedge op_clock);
        ctrl_wr <= 1'b0;
    endtask

    task automatic wait_mesrst(input logic level);
        wait_cnt = 0;
        do
        begin
            @(negedge op_clock);                 // Outputs are settled at the falling edge.
            wait_cnt++;
            if (wait_cnt > 50)
                report_failure("Timeout waiting for mesrst to reach the expected level.");
        end
        while (mesrst !== level);
    endtask

    // Interval trackers, updated where the outputs are stable.
    always @(negedge op_clock)
    begin
        dpulse_prev <= dpulse;
        ppulse_prev <= ppulse;
        if (chk_scan && dpulse && !dpulse_prev)
        begin
            rises <= rises + 1;                  // New scan pulse seen.
            gap <= 1;
        end
        else
            gap <= gap + 1;
        if (chk_pre && ppulse != ppulse_prev)
        begin
            pre_changes <= pre_changes + 1;      // Precharge level flipped.
            run_len <= 1;
        end
        else
            run_len <= run_len + 1;
    end

    idle_low_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        chk_idle |-> !(start0 || start1 || mesrst || dpulse || ppulse || shield))
        else report_failure($sformatf("FAIL outputs after reset = %h, expected 00",
            {start0, start1, mesrst, dpulse, ppulse, shield}));

    mesrst_hold_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        meas_pending |-> mesrst)
        else report_failure($sformatf("FAIL mesrst = %h, expected 1", mesrst));

    start_match_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        chk_start |-> (start0 == exp_ch0 && start1 == exp_ch1 && !mesrst))
        else report_failure($sformatf("FAIL start1,start0 = %h, expected %h",
            {start1, start0}, {exp_ch1, exp_ch0}));

    stopped_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        chk_stopped |-> !(start0 || start1 || mesrst))
        else report_failure($sformatf("FAIL start0,start1,mesrst = %h, expected 0",
            {start0, start1, mesrst}));

    scan_gap_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        (chk_scan && rises > 0 && $rose(dpulse)) |-> gap == 32)
        else report_failure($sformatf("FAIL dpulse period = %h, expected %h", gap, 32));

    scan_width_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        (chk_scan && $rose(dpulse)) |=> !dpulse)
        else report_failure($sformatf("FAIL dpulse = %h, expected 0", dpulse));

    pre_half_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        (chk_pre && pre_changes > 0 && $changed(ppulse)) |-> run_len == 4)
        else report_failure($sformatf("FAIL ppulse run = %h, expected %h", run_len, 4));

    shield_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        shield == ppulse)
        else report_failure($sformatf("FAIL shield = %h, expected %h", shield, ppulse));

    freeze_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        chk_frz |-> ($stable(dpulse) && $stable(ppulse)))
        else report_failure($sformatf("FAIL dpulse,ppulse = %h while frozen",
            {dpulse, ppulse}));

    prs_match_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        prs_sample |-> ppulse == exp_msb)
        else report_failure($sformatf("FAIL ppulse = %h, expected %h", ppulse, exp_msb));

    prs_moves_a: assert property (@(negedge op_clock) disable iff (inter_reset)
        prs_done |-> prs_toggled)
        else report_failure("The PRS output never changed within 16 steps.");

    initial
    begin
        lfsr_state = 32'h6be5_6a2b;
        {chk_idle, meas_pending, chk_start, chk_stopped} = '0;
        {chk_scan, chk_pre, chk_frz, prs_sample, prs_done} = '0;
        {exp_ch0, exp_ch1, exp_msb, prs_first, prs_toggled} = '0;
        {rises, gap, pre_changes, run_len, wait_cnt, frz_len} = '0;
        {dpulse_prev, ppulse_prev} = '0;
        ch_bits = '0;
        prs_model = '0;
        inter_reset = 1'b1;
        enable = 1'b0;
        ctrl_wr = 1'b0;
        ctrl_wdata = '0;
        repeat (3) @(posedge op_clock);
        inter_reset <= 1'b0;                     // Release after 3 cycles.

        @(negedge op_clock);
        chk_idle = 1'b1;                         // Everything quiet until the first write.
        repeat (6) @(negedge op_clock);
        chk_idle = 1'b0;

        take_bit(exp_ch0);
        take_bit(exp_ch1);
        ch_bits[csd_seq_pkg::CTRL_CH0_EN] = exp_ch0;
        ch_bits[csd_seq_pkg::CTRL_CH1_EN] = exp_ch1;
        write_ctrl(ch_bits | 8'h01);
        wait_mesrst(1'b1);
        meas_pending = 1'b1;                     // Measurement reset must hold on its own.
        repeat (6) @(negedge op_clock);
        write_ctrl(ch_bits | 8'h03);
        meas_pending = 1'b0;
        wait_mesrst(1'b0);
        chk_start = 1'b1;
        repeat (4) @(negedge op_clock);
        chk_start = 1'b0;
        write_ctrl(8'h0E);                       // Drop sync only, so the FSM must stop the starts.
        repeat (2) @(negedge op_clock);
        chk_stopped = 1'b1;
        repeat (4) @(negedge op_clock);
        chk_stopped = 1'b0;

        @(posedge op_clock);
        enable <= 1'b1;
        @(negedge op_clock);
        chk_scan = 1'b1;
        chk_pre = 1'b1;
        wait_cnt = 0;
        while (rises < 3 || pre_changes < 6)
        begin
            @(negedge op_clock);
            wait_cnt++;
            if (wait_cnt > 200)
                report_failure("Timeout waiting for dpulse and ppulse activity.");
        end
        chk_scan = 1'b0;
        chk_pre = 1'b0;

        frz_len = 5;
        for (int i = 0; i < 4; i++)
        begin
            logic b;
            take_bit(b);
            frz_len += int'(b) << i;             // Random hold of 5 to 20 cycles.
        end
        @(posedge op_clock);
        enable <= 1'b0;
        @(negedge op_clock);
        chk_frz = 1'b1;
        repeat (frz_len) @(negedge op_clock);
        chk_frz = 1'b0;
        @(posedge op_clock);
        enable <= 1'b1;

        write_ctrl(8'h11);                       // Sync with the PRS as source.
        wait_mesrst(1'b1);                       // Generators were reset on this edge.
        prs_model = 8'hFF;
        repeat (5) @(negedge op_clock);          // Into the middle of the first step.
        for (int k = 0; k < 16; k++)
        begin
            prs_model = {prs_model[6:0], 1'b0} ^ (prs_model[7] ? 8'h71 : 8'h00);
            exp_msb = prs_model[7];
            prs_sample = 1'b1;
            @(negedge op_clock);
            prs_sample = 1'b0;
            if (k == 0)
                prs_first = ppulse;
            else if (ppulse != prs_first)
                prs_toggled = 1'b1;              // Output is not stuck.
            repeat (7) @(negedge op_clock);
        end
        prs_done = 1'b1;
        @(negedge op_clock);
        prs_done = 1'b0;
        @(negedge op_clock);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/csd_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module csd_clock_gen
#(
    parameter int unsigned SCAN_PERIOD = csd_cfg_pkg::SCAN_PERIOD_DEF,
    parameter int unsigned PRE_PERIOD = csd_cfg_pkg::PRE_PERIOD_DEF,
    parameter int unsigned PRS_WIDTH = 8,
    parameter bit          SHIELD_INVERT = 1'b0
)
(
    input  wire logic                            op_clock,
    input  wire logic                            inter_reset,
    input  wire logic                            enable,
    input  wire logic                            ctrl_wr,
    input  wire logic [csd_seq_pkg::CTRL_W-1:0]  ctrl_wdata,
    output logic                                 dpulse,
    output logic                                 ppulse,
    output logic                                 start0,
    output logic                                 start1,
    output logic                                 mesrst,
    output logic                                 shield
);

    logic gen_rst;                               // One-cycle reset of all generators.
    logic prs_sel;                               // Picks the PRS over the square clock.
    logic pre_clk;                               // Square precharge clock.
    logic pre_edge;                              // Rising edge strobe of pre_clk.
    logic prs_bit;                               // Spread-spectrum precharge clock.

    csd_scan_sequencer u_csd_scan_sequencer
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .ctrl_wr     (ctrl_wr),
        .ctrl_wdata  (ctrl_wdata),
        .gen_rst     (gen_rst),
        .prs_sel     (prs_sel),
        .mesrst      (mesrst),
        .start0      (start0),
        .start1      (start1)
    );

    csd_scan_counter #(.SCAN_PERIOD(SCAN_PERIOD)) u_csd_scan_counter
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .enable      (enable),
        .gen_rst     (gen_rst),
        .dpulse      (dpulse)
    );

    csd_prescaler #(.PRE_PERIOD(PRE_PERIOD)) u_csd_prescaler
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .enable      (enable),
        .gen_rst     (gen_rst),
        .pre_clk     (pre_clk),
        .pre_edge    (pre_edge)
    );

    csd_prs_gen #(.PRS_WIDTH(PRS_WIDTH)) u_csd_prs_gen
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .gen_rst     (gen_rst),
        .pre_edge    (pre_edge),
        .prs_bit     (prs_bit)
    );

    assign ppulse = prs_sel ? prs_bit : pre_clk; // Precharge source select.
    assign shield = ppulse ^ SHIELD_INVERT;      // Sink IDAC mode wants the inverted shield.

endmodule

`default_nettype wire

// File: precharge/csd_prs_gen.sv
`timescale 1ns/1ps
`default_nettype none

module csd_prs_gen
#(
    parameter int unsigned PRS_WIDTH = 8
)
(
    input  wire logic op_clock,
    input  wire logic inter_reset,
    input  wire logic gen_rst,
    input  wire logic pre_edge,
    output logic      prs_bit
);

    localparam logic [csd_cfg_pkg::PRS_W_MAX-1:0] POLY_FULL =
        (PRS_WIDTH == 16) ? csd_cfg_pkg::PRS16_POLY : csd_cfg_pkg::PRS8_POLY;
    localparam logic [PRS_WIDTH-1:0] POLY = POLY_FULL[PRS_WIDTH-1:0]; // Taps at this width.

    logic [PRS_WIDTH-1:0] lfsr_q;                // Galois shift register.
    logic [PRS_WIDTH-1:0] mixed;                 // Register after the tap XOR.
    logic [PRS_WIDTH-1:0] lfsr_d;                // Register after one step.
    logic msb;

    assign msb = lfsr_q[PRS_WIDTH-1];

    // The taps are XORed in when the MSB is one, then the word shifts left
    // with the old MSB entering bit 0, which supplies the x^0 term.
    assign mixed = lfsr_q ^ (msb ? POLY : '0);
    assign lfsr_d = {mixed[PRS_WIDTH-2:0], msb};

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            lfsr_q <= '1;                        // All ones, any nonzero seed would do.
        end
        else if (gen_rst)
        begin
            lfsr_q <= '1;                        // Same seed at every scan start.
        end
        else if (pre_edge)
        begin
            lfsr_q <= lfsr_d;                    // One step per precharge rising edge.
        end
    end

    assign prs_bit = msb;                        // MSB is already a flop output.

    // A maximal polynomial never reaches the lock-up state from a nonzero seed.
    lfsr_nonzero_a: assert property (@(posedge op_clock) disable iff (inter_reset)
        lfsr_q != '0);

    initial
    begin
        width_ok_a: assert (PRS_WIDTH == 8 || PRS_WIDTH == 16)
            else $error("PRS width %0d has no polynomial", PRS_WIDTH);
    end

endmodule

`default_nettype wire

// File: precharge/csd_prescaler.sv
`timescale 1ns/1ps
`default_nettype none

module csd_prescaler
#(
    parameter int unsigned PRE_PERIOD = csd_cfg_pkg::PRE_PERIOD_DEF
)
(
    input  wire logic op_clock,
    input  wire logic inter_reset,
    input  wire logic enable,
    input  wire logic gen_rst,
    output logic      pre_clk,
    output logic      pre_edge
);

    localparam logic [csd_cfg_pkg::PRE_CNT_W-1:0] LAST =
        csd_cfg_pkg::PRE_CNT_W'(PRE_PERIOD - 1); // Final phase before the wrap.
    localparam logic [csd_cfg_pkg::PRE_CNT_W-1:0] HALF =
        csd_cfg_pkg::PRE_CNT_W'(PRE_PERIOD / 2); // Phases below this drive the clock high.

    logic [csd_cfg_pkg::PRE_CNT_W-1:0] count_q;  // Phase within the precharge period.
    logic pre_clk_dly;                           // Precharge clock one enabled cycle ago.

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            count_q <= '0;
            pre_clk <= 1'b0;                     // Precharge idles low.
            pre_clk_dly <= 1'b0;
        end
        else if (gen_rst)
        begin
            count_q <= '0;                       // Restart the period with the scan.
            pre_clk <= 1'b0;
            pre_clk_dly <= 1'b0;
        end
        else if (enable)
        begin
            if (count_q == LAST)
            begin
                count_q <= '0;                   // End of period.
            end
            else
            begin
                count_q <= count_q + 1'b1;
            end
            pre_clk <= (count_q < HALF);         // High half first, then low half.
            pre_clk_dly <= pre_clk;              // Tracks the edge on enabled cycles only.
        end
    end

    // First enabled cycle with the clock seen high, so the edge waits out a freeze.
    assign pre_edge = enable & pre_clk & ~pre_clk_dly;

    edge_in_high_a: assert property (@(posedge op_clock) disable iff (inter_reset)
        pre_edge |-> pre_clk);

endmodule

`default_nettype wire

// File: hdl/csd_scan_counter.sv
`timescale 1ns/1ps
`default_nettype none

module csd_scan_counter
#(
    parameter int unsigned SCAN_PERIOD = csd_cfg_pkg::SCAN_PERIOD_DEF
)
(
    input  wire logic op_clock,
    input  wire logic inter_reset,
    input  wire logic enable,
    input  wire logic gen_rst,
    output logic      dpulse
);

    localparam logic [csd_cfg_pkg::SCAN_CNT_W-1:0] RELOAD =
        csd_cfg_pkg::SCAN_CNT_W'(SCAN_PERIOD);   // Value loaded at start and after zero.

    logic [csd_cfg_pkg::SCAN_CNT_W-1:0] count_q; // Cycles left until the next dpulse.

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            count_q <= RELOAD;                   // Start a full period out of reset.
        end
        else if (gen_rst)
        begin
            count_q <= RELOAD;                   // Realign to the new scan.
        end
        else if (enable)
        begin
            if (count_q == '0)
            begin
                count_q <= RELOAD;               // Terminal count reached, so wrap.
            end
            else
            begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign dpulse = (count_q == '0);             // One cycle in SCAN_PERIOD+1 when enabled.

    count_range_a: assert property (@(posedge op_clock) disable iff (inter_reset)
        count_q <= RELOAD);

endmodule

`default_nettype wire

// File: hdl/csd_scan_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module csd_scan_sequencer
(
    input  wire logic                            op_clock,
    input  wire logic                            inter_reset,
    input  wire logic                            ctrl_wr,
    input  wire logic [csd_seq_pkg::CTRL_W-1:0]  ctrl_wdata,
    output logic                                 gen_rst,
    output logic                                 prs_sel,
    output logic                                 mesrst,
    output logic                                 start0,
    output logic                                 start1
);

    logic [csd_seq_pkg::CTRL_W-1:0] ctrl_q;      // Control word as last written by the CPU.
    csd_seq_pkg::seq_state_t state_q;            // Current sequencer state.
    csd_seq_pkg::seq_state_t state_d;            // State for the next cycle.
    logic sync_en;
    logic meas_en;
    logic ch0_en;
    logic ch1_en;
    logic work_en;

    // The word is stored on the strobe and acts from the next cycle on.
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            ctrl_q <= '0;                        // All functions off after reset.
        end
        else if (ctrl_wr)
        begin
            ctrl_q <= ctrl_wdata;                // Capture the new control word.
        end
    end

    assign sync_en = ctrl_q[csd_seq_pkg::CTRL_SYNC_EN];
    assign meas_en = ctrl_q[csd_seq_pkg::CTRL_MEAS_EN];
    assign ch0_en = ctrl_q[csd_seq_pkg::CTRL_CH0_EN];
    assign ch1_en = ctrl_q[csd_seq_pkg::CTRL_CH1_EN];

    always_comb
    begin
        state_d = state_q;                       // Hold unless a condition below fires.
        case (state_q)
            csd_seq_pkg::SEQ_IDLE:
            begin
                if (sync_en)
                begin
                    state_d = csd_seq_pkg::SEQ_GEN_RST; // Kick off a new scan.
                end
            end
            csd_seq_pkg::SEQ_GEN_RST:
            begin
                state_d = csd_seq_pkg::SEQ_MEAS_RST;    // Generator reset is a single cycle.
            end
            csd_seq_pkg::SEQ_MEAS_RST:
            begin
                if (meas_en)
                begin
                    state_d = csd_seq_pkg::SEQ_WORK;    // CPU lets the measurement start.
                end
            end
            csd_seq_pkg::SEQ_WORK:
            begin
                if (!sync_en)
                begin
                    state_d = csd_seq_pkg::SEQ_IDLE;    // Sync dropped, so stop the scan.
                end
            end
            default:
            begin
                state_d = csd_seq_pkg::SEQ_IDLE;        // Recover from an illegal code.
            end
        endcase
    end

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            state_q <= csd_seq_pkg::SEQ_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // Outputs come straight off the state flops and so lag the deciding edge by one cycle.
    assign gen_rst = state_q[0];                 // Generator reset bit.
    assign mesrst = state_q[1];                  // Measurement reset bit.
    assign work_en = state_q[2];                 // Work bit.
    assign start0 = work_en & ch0_en;            // Channel 0 runs only while working.
    assign start1 = work_en & ch1_en;
    assign prs_sel = ctrl_q[csd_seq_pkg::CTRL_PRS_SEL]; // Source select bypasses the FSM.

    state_legal_a: assert property (@(posedge op_clock) disable iff (inter_reset)
        state_q inside {csd_seq_pkg::SEQ_IDLE, csd_seq_pkg::SEQ_GEN_RST,
                        csd_seq_pkg::SEQ_MEAS_RST, csd_seq_pkg::SEQ_WORK});

    gen_rst_single_a: assert property (@(posedge op_clock) disable iff (inter_reset)
        gen_rst |=> !gen_rst);

    start_no_mesrst_a: assert property (@(posedge op_clock) disable iff (inter_reset)
        (start0 || start1) |-> !mesrst);

endmodule

`default_nettype wire

// File: common/csd_seq_pkg.sv
`default_nettype none

package csd_seq_pkg;

    localparam int unsigned CTRL_W = 8;          // Width of the CPU control word.

    // Bit positions in the control word. Bits 5 to 7 are reserved.
    localparam int unsigned CTRL_SYNC_EN = 0;    // Starts the sequence, clearing it stops.
    localparam int unsigned CTRL_MEAS_EN = 1;    // Releases the measurement reset.
    localparam int unsigned CTRL_CH0_EN = 2;     // Enables the channel 0 start.
    localparam int unsigned CTRL_CH1_EN = 3;     // Enables the channel 1 start.
    localparam int unsigned CTRL_PRS_SEL = 4;    // Selects the PRS as precharge source.

    // Each active state owns one bit, so the outputs decode straight from the flops.
    typedef enum logic [2:0]
    {
        SEQ_IDLE = 3'b000,                       // Waiting for sync enable.
        SEQ_GEN_RST = 3'b001,                    // Bit 0 resets the generators.
        SEQ_MEAS_RST = 3'b010,                   // Bit 1 holds the measurement reset.
        SEQ_WORK = 3'b100                        // Bit 2 lets the channels run.
    } seq_state_t;

endpackage

`default_nettype wire

// File: common/csd_cfg_pkg.sv
`default_nettype none

package csd_cfg_pkg;

    // Scan-speed counter.
    localparam int unsigned SCAN_CNT_W = 7;      // Width of the scan-speed down counter.
    localparam int unsigned SCAN_PERIOD_DEF = 31; // Terminal value, so one dpulse in 32.

    // Precharge prescaler.
    localparam int unsigned PRE_CNT_W = 8;       // Width of the prescaler phase counter.
    localparam int unsigned PRE_PERIOD_DEF = 8;  // Enabled cycles per precharge period.

    // Pseudo-random sequence generator.
    localparam int unsigned PRS_W_MAX = 16;      // Widest shift register supported.

    // The polynomials hold the taps of x^W down to x^1 in bits W-1 to 0.
    // The x^0 term is implied by feeding the old MSB back into bit 0.
    localparam logic [PRS_W_MAX-1:0] PRS8_POLY = 16'h00B8;  // x^8+x^6+x^5+x^4+1.
    localparam logic [PRS_W_MAX-1:0] PRS16_POLY = 16'hB400; // x^16+x^14+x^13+x^11+1.

endpackage

`default_nettype wire
